//--- logic/gmii_rx_pkg.sv
// receiver package: byte and state types, ethernet framing and crc-32 constants
package gmii_rx_pkg;

    // one gmii data byte
    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PIPE    = 2'd1,
        ST_PAYLOAD = 2'd2
    } rx_state_t;

    // preamble and start-of-frame delimiter
    localparam byte_t ETH_PRE = 8'h55;
    localparam byte_t ETH_SFD = 8'hD5;

    // ieee 802.3 crc-32, normal (msb-first) form
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

    // register value left behind once a correct fcs has been shifted in
    localparam logic [31:0] CRC_RESIDUE = ~32'h2144_DF1C;

    // sfd at the tail while the fcs sits at the head
    localparam int PIPE_DEPTH = 5;

    // frame length counters and configured limit
    localparam int LEN_W = 16;

endpackage

//--- logic/gmii_pipe_if.sv
// receive delay line taps: head and tail data, data-valid and error
interface gmii_pipe_if;

    // stage 0
    gmii_rx_pkg::byte_t head_data;
    logic               head_dv;
    logic               head_er;

    // last stage
    gmii_rx_pkg::byte_t tail_data;
    logic               tail_dv;
    logic               tail_er;

    modport src (
        output head_data, head_dv, head_er,
        output tail_data, tail_dv, tail_er
    );

    modport dst (
        input head_data, head_dv, head_er,
        input tail_data, tail_dv, tail_er
    );

endinterface

//--- logic/gmii_delay_line.sv
// gmii receive delay line: data, data-valid and error shifted through the pipe stages
module gmii_delay_line (
    input  logic               clk,
    input  logic               reset_crc,
    input  gmii_rx_pkg::byte_t gmii_rxd,
    input  logic               gmii_rx_dv,
    input  logic               gmii_rx_er,
    gmii_pipe_if.src           taps
);

    gmii_rx_pkg::byte_t                 data_q [gmii_rx_pkg::PIPE_DEPTH];
    logic [gmii_rx_pkg::PIPE_DEPTH-1:0] dv_q;
    logic [gmii_rx_pkg::PIPE_DEPTH-1:0] er_q;

    // data bytes carry no reset
    always_ff @(posedge clk) begin
        data_q[0] <= gmii_rxd;
        for (int i = 1; i < gmii_rx_pkg::PIPE_DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            dv_q <= '0;
            er_q <= '0;
        end else begin
            dv_q <= {dv_q[gmii_rx_pkg::PIPE_DEPTH-2:0], gmii_rx_dv};
            // rx_er outside of rx_dv is carrier signalling, not a frame error
            er_q <= {er_q[gmii_rx_pkg::PIPE_DEPTH-2:0], gmii_rx_er & gmii_rx_dv};
        end
    end

    assign taps.head_data = data_q[0];
    assign taps.head_dv   = dv_q[0];
    assign taps.head_er   = er_q[0];

    assign taps.tail_data = data_q[gmii_rx_pkg::PIPE_DEPTH-1];
    assign taps.tail_dv   = dv_q[gmii_rx_pkg::PIPE_DEPTH-1];
    assign taps.tail_er   = er_q[gmii_rx_pkg::PIPE_DEPTH-1];

    // errors stay tied to valid bytes all the way down the pipe
    a_er_within_dv: assert property (
        @(posedge clk) disable iff (reset_crc)
        (er_q & ~dv_q) == '0
    ) else $error("delay line error bit set on an invalid stage");

endmodule

//--- logic/eth_fcs_check.sv
// ethernet fcs check: byte-wise reflected crc-32 register and residue compare
module eth_fcs_check (
    input  logic     clk,
    input  logic     reset_crc,
    input  logic     crc_init,
    input  logic     crc_update,
    gmii_pipe_if.dst taps,
    output logic     fcs_ok
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic [31:0] poly_rev;

    // bit-reversed polynomial for the lsb-first shift
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            poly_rev[i] = gmii_rx_pkg::CRC_POLY[31-i];
        end
    end

    // eight galois steps over the head byte, lsb first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ taps.head_data[i]) begin
                crc_next = (crc_next >> 1) ^ poly_rev;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_init) begin
            crc_q <= '1;
        end else if (crc_update) begin
            crc_q <= crc_next;
        end
    end

    // head holds the last fcs byte when this is sampled
    assign fcs_ok = (crc_next == gmii_rx_pkg::CRC_RESIDUE);

    a_init_update_excl: assert property (
        @(posedge clk) disable iff (reset_crc)
        !(crc_init && crc_update)
    ) else $error("crc init and update requested together");

endmodule

//--- logic/eth_addr_classify.sv
// destination address classifier: header byte pointer, multicast and broadcast flags
module eth_addr_classify (
    input  logic     clk,
    input  logic     reset_crc,
    input  logic     hdr_clear,
    input  logic     hdr_step,
    gmii_pipe_if.dst taps,
    output logic     is_mcast,
    output logic     is_bcast
);

    logic [2:0] hdr_ptr_q;
    logic       mcast_q;
    logic       bcast_q;
    logic       byte_ones;

    assign byte_ones = (taps.tail_data == 8'hFF);

    always_ff @(posedge clk) begin
        if (reset_crc || hdr_clear) begin
            hdr_ptr_q <= '0;
            mcast_q   <= 1'b0;
            bcast_q   <= 1'b0;
        end else if (hdr_step) begin
            // saturate past the address bytes
            if (!(&hdr_ptr_q)) begin
                hdr_ptr_q <= hdr_ptr_q + 3'd1;
            end

            if (hdr_ptr_q == 3'd0) begin
                // group bit is the lsb of the first byte on the wire
                mcast_q <= taps.tail_data[0];
                bcast_q <= byte_ones;
            end else if (hdr_ptr_q <= 3'd5) begin
                bcast_q <= bcast_q && byte_ones;
            end
        end
    end

    assign is_mcast = mcast_q;
    assign is_bcast = bcast_q;

endmodule

//--- logic/eth_rx_fsm.sv
// receive frame fsm: sfd search, length counters, output stream and status pulses
module eth_rx_fsm (
    input  logic                          clk,
    input  logic                          reset_crc,
    gmii_pipe_if.dst                      taps,
    input  logic                          gmii_rx_dv,
    input  logic                          gmii_rx_er,
    input  logic [gmii_rx_pkg::LEN_W-1:0] cfg_max_pkt_len,
    input  logic                          fcs_ok,
    input  logic                          is_mcast,
    input  logic                          is_bcast,
    output logic                          crc_init,
    output logic                          crc_update,
    output logic                          hdr_clear,
    output logic                          hdr_step,
    output gmii_rx_pkg::byte_t            rx_data,
    output logic                          rx_valid,
    output logic                          rx_last,
    output logic                          rx_bad,
    output logic [gmii_rx_pkg::LEN_W-1:0] stat_pkt_len,
    output logic                          stat_pkt_good,
    output logic                          stat_pkt_bad,
    output logic                          stat_err_bad_fcs,
    output logic                          stat_err_oversize,
    output logic                          stat_err_bad_block,
    output logic                          stat_pkt_ucast,
    output logic                          stat_pkt_mcast,
    output logic                          stat_pkt_bcast
);

    gmii_rx_pkg::rx_state_t        state_q;
    logic                          in_pre_q;
    logic                          pre_seen_q;
    logic                          frame_err_q;
    logic [gmii_rx_pkg::LEN_W-1:0] len_q;
    logic [gmii_rx_pkg::LEN_W-1:0] lim_q;

    logic head_pre;
    logic head_sfd;
    logic tail_sfd;
    logic oversize;
    logic frame_bad;

    assign head_pre = taps.head_dv && !taps.head_er && (taps.head_data == gmii_rx_pkg::ETH_PRE);
    assign head_sfd = taps.head_dv && !taps.head_er && (taps.head_data == gmii_rx_pkg::ETH_SFD);
    assign tail_sfd = taps.tail_dv && !taps.tail_er && (taps.tail_data == gmii_rx_pkg::ETH_SFD);

    // limit counter ran out before the end of the frame
    assign oversize  = (lim_q == '0);
    assign frame_bad = frame_err_q || !fcs_ok || oversize;

    always_comb begin
        crc_init   = (state_q == gmii_rx_pkg::ST_IDLE);
        crc_update = (state_q == gmii_rx_pkg::ST_PIPE) ||
                     (state_q == gmii_rx_pkg::ST_PAYLOAD && gmii_rx_dv);
        hdr_clear  = (state_q != gmii_rx_pkg::ST_PAYLOAD);
        hdr_step   = (state_q == gmii_rx_pkg::ST_PAYLOAD);
    end

    // clean preamble since the last gap, and the byte before the head was 0x55
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            in_pre_q   <= 1'b0;
            pre_seen_q <= 1'b0;
        end else begin
            in_pre_q   <= !taps.head_dv || (in_pre_q && head_pre);
            pre_seen_q <= head_pre;
        end
    end

    always_ff @(posedge clk) begin
        rx_data            <= taps.tail_data;
        rx_valid           <= 1'b0;
        rx_last            <= 1'b0;
        rx_bad             <= 1'b0;
        stat_pkt_len       <= '0;
        stat_pkt_good      <= 1'b0;
        stat_pkt_bad       <= 1'b0;
        stat_err_bad_fcs   <= 1'b0;
        stat_err_oversize  <= 1'b0;
        stat_err_bad_block <= 1'b0;
        stat_pkt_ucast     <= 1'b0;
        stat_pkt_mcast     <= 1'b0;
        stat_pkt_bcast     <= 1'b0;

        if (state_q != gmii_rx_pkg::ST_IDLE) begin
            if (!(&len_q)) begin
                len_q <= len_q + 1'b1;
            end
            if (lim_q != '0) begin
                lim_q <= lim_q - 1'b1;
            end
            if (gmii_rx_dv && gmii_rx_er) begin
                frame_err_q <= 1'b1;
            end
        end

        case (state_q)
            gmii_rx_pkg::ST_IDLE: begin
                frame_err_q <= 1'b0;
                len_q       <= 1;
                lim_q       <= cfg_max_pkt_len;
                if (head_sfd && in_pre_q && pre_seen_q) begin
                    state_q <= gmii_rx_pkg::ST_PIPE;
                end
            end
            gmii_rx_pkg::ST_PIPE: begin
                // head already crosses the address, wait for the sfd to drain
                if (tail_sfd) begin
                    state_q <= gmii_rx_pkg::ST_PAYLOAD;
                end
            end
            gmii_rx_pkg::ST_PAYLOAD: begin
                rx_valid <= 1'b1;
                if (!gmii_rx_dv) begin
                    // the four fcs bytes are still in the pipe and get dropped
                    rx_last            <= 1'b1;
                    rx_bad             <= frame_bad;
                    stat_pkt_len       <= len_q;
                    stat_pkt_good      <= !frame_bad;
                    stat_pkt_bad       <= frame_bad;
                    stat_err_bad_fcs   <= !frame_err_q && !fcs_ok;
                    stat_err_oversize  <= oversize;
                    stat_err_bad_block <= frame_err_q;
                    stat_pkt_ucast     <= !is_mcast;
                    stat_pkt_mcast     <= is_mcast && !is_bcast;
                    stat_pkt_bcast     <= is_bcast;
                    state_q            <= gmii_rx_pkg::ST_IDLE;
                end
            end
            default: begin
                state_q <= gmii_rx_pkg::ST_IDLE;
            end
        endcase

        if (reset_crc) begin
            state_q            <= gmii_rx_pkg::ST_IDLE;
            rx_valid           <= 1'b0;
            rx_last            <= 1'b0;
            stat_pkt_len       <= '0;
            stat_pkt_good      <= 1'b0;
            stat_pkt_bad       <= 1'b0;
            stat_err_bad_fcs   <= 1'b0;
            stat_err_oversize  <= 1'b0;
            stat_err_bad_block <= 1'b0;
            stat_pkt_ucast     <= 1'b0;
            stat_pkt_mcast     <= 1'b0;
            stat_pkt_bcast     <= 1'b0;
        end
    end

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (reset_crc)
        rx_last |-> rx_valid
    ) else $error("rx_last without rx_valid");

    a_good_bad_excl: assert property (
        @(posedge clk) disable iff (reset_crc)
        !(stat_pkt_good && stat_pkt_bad)
    ) else $error("frame reported both good and bad");

endmodule

//--- logic/gmii_frame_rx.sv
// gmii frame receiver top: delay line, fcs check, address classifier and frame fsm
module gmii_frame_rx (
    input  logic                          clk,
    input  logic                          reset_crc,
    input  gmii_rx_pkg::byte_t            gmii_rxd,
    input  logic                          gmii_rx_dv,
    input  logic                          gmii_rx_er,
    input  logic [gmii_rx_pkg::LEN_W-1:0] cfg_max_pkt_len,
    output gmii_rx_pkg::byte_t            rx_data,
    output logic                          rx_valid,
    output logic                          rx_last,
    output logic                          rx_bad,
    output logic [gmii_rx_pkg::LEN_W-1:0] stat_pkt_len,
    output logic                          stat_pkt_good,
    output logic                          stat_pkt_bad,
    output logic                          stat_err_bad_fcs,
    output logic                          stat_err_oversize,
    output logic                          stat_err_bad_block,
    output logic                          stat_pkt_ucast,
    output logic                          stat_pkt_mcast,
    output logic                          stat_pkt_bcast
);

    logic crc_init;
    logic crc_update;
    logic fcs_ok;
    logic hdr_clear;
    logic hdr_step;
    logic is_mcast;
    logic is_bcast;

    gmii_pipe_if taps ();

    gmii_delay_line u_delay_line (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .taps       (taps.src)
    );

    eth_fcs_check u_fcs_check (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .taps       (taps.dst),
        .fcs_ok     (fcs_ok)
    );

    eth_addr_classify u_addr_classify (
        .clk       (clk),
        .reset_crc (reset_crc),
        .hdr_clear (hdr_clear),
        .hdr_step  (hdr_step),
        .taps      (taps.dst),
        .is_mcast  (is_mcast),
        .is_bcast  (is_bcast)
    );

    eth_rx_fsm u_rx_fsm (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .taps               (taps.dst),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .cfg_max_pkt_len    (cfg_max_pkt_len),
        .fcs_ok             (fcs_ok),
        .is_mcast           (is_mcast),
        .is_bcast           (is_bcast),
        .crc_init           (crc_init),
        .crc_update         (crc_update),
        .hdr_clear          (hdr_clear),
        .hdr_step           (hdr_step),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .rx_last            (rx_last),
        .rx_bad             (rx_bad),
        .stat_pkt_len       (stat_pkt_len),
        .stat_pkt_good      (stat_pkt_good),
        .stat_pkt_bad       (stat_pkt_bad),
        .stat_err_bad_fcs   (stat_err_bad_fcs),
        .stat_err_oversize  (stat_err_oversize),
        .stat_err_bad_block (stat_err_bad_block),
        .stat_pkt_ucast     (stat_pkt_ucast),
        .stat_pkt_mcast     (stat_pkt_mcast),
        .stat_pkt_bcast     (stat_pkt_bcast)
    );

endmodule

//--- dv/gmii_frame_ref.svh
// reference model: crc-32, gmii frame builder and expected per-frame status
`ifndef GMII_FRAME_REF_SVH
`define GMII_FRAME_REF_SVH

typedef gmii_rx_pkg::byte_t byte_q_t[$];

typedef struct packed {
    logic [gmii_rx_pkg::LEN_W-1:0] len;
    logic                          good;
    logic                          bad;
    logic                          bad_fcs;
    logic                          oversize;
    logic                          bad_block;
    logic                          ucast;
    logic                          mcast;
    logic                          bcast;
} exp_stat_t;

// reflected crc-32, init all ones, no final inversion
function automatic logic [31:0] crc32_reflected(input byte_q_t data);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (data[i]) begin
        crc = crc ^ {24'h0, data[i]};
        for (int b = 0; b < 8; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ 32'hEDB8_8320;
            end else begin
                crc = crc >> 1;
            end
        end
    end
    return crc;
endfunction

// preamble, sfd, payload, then fcs low byte first
function automatic byte_q_t build_frame(input byte_q_t payload, input bit bad_fcs);
    byte_q_t     frame;
    logic [31:0] fcs;
    fcs = ~crc32_reflected(payload);
    if (bad_fcs) begin
        fcs[27] = ~fcs[27];
    end
    for (int i = 0; i < 7; i++) begin
        frame.push_back(gmii_rx_pkg::ETH_PRE);
    end
    frame.push_back(gmii_rx_pkg::ETH_SFD);
    foreach (payload[i]) begin
        frame.push_back(payload[i]);
    end
    for (int i = 0; i < 4; i++) begin
        frame.push_back(fcs[8*i +: 8]);
    end
    return frame;
endfunction

function automatic exp_stat_t expect_status(input byte_q_t payload, input bit bad_fcs,
                                            input bit rx_err, input int max_len);
    exp_stat_t st;
    int        frame_len;
    bit        all_ones;
    frame_len = payload.size() + 4;
    all_ones  = 1'b1;
    for (int i = 0; i < 6; i++) begin
        if (payload[i] != 8'hFF) begin
            all_ones = 1'b0;
        end
    end
    st.len       = frame_len[gmii_rx_pkg::LEN_W-1:0];
    st.oversize  = (frame_len > max_len);
    st.bad_block = rx_err;
    st.bad       = rx_err || bad_fcs || st.oversize;
    st.good      = !st.bad;
    st.bad_fcs   = !rx_err && bad_fcs;
    // group bit is the lsb of the first destination byte
    st.ucast     = !payload[0][0];
    st.mcast     = payload[0][0] && !all_ones;
    st.bcast     = all_ones;
    return st;
endfunction

`endif

//--- dv/gmii_frame_rx_tb.sv
// testbench for gmii_frame_rx: clock, reset, frame stimulus, output checker and watchdog
module gmii_frame_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "gmii_frame_ref.svh"

    typedef enum int {DST_UCAST, DST_MCAST, DST_BCAST, DST_RANDOM} dst_kind_t;

    logic                          clk;
    logic                          reset_crc;
    gmii_rx_pkg::byte_t            gmii_rxd;
    logic                          gmii_rx_dv;
    logic                          gmii_rx_er;
    logic [gmii_rx_pkg::LEN_W-1:0] cfg_max_pkt_len;
    gmii_rx_pkg::byte_t            rx_data;
    logic                          rx_valid;
    logic                          rx_last;
    logic                          rx_bad;
    logic [gmii_rx_pkg::LEN_W-1:0] stat_pkt_len;
    logic stat_pkt_good;
    logic stat_pkt_bad;
    logic stat_err_bad_fcs;
    logic stat_err_oversize;
    logic stat_err_bad_block;
    logic stat_pkt_ucast;
    logic stat_pkt_mcast;
    logic stat_pkt_bcast;

    int                 seed = 32'h592c_beac;
    byte_q_t            payload;
    gmii_rx_pkg::byte_t exp_data_q[$];
    bit                 exp_last_q[$];
    exp_stat_t          exp_stat_q[$];
    string              exp_name_q[$];
    int                 frames_sent = 0;
    int                 frames_seen = 0;

    gmii_frame_rx dut (.*);

    always #10 clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic make_payload(input int plen, input dst_kind_t kind);
        payload.delete();
        for (int i = 0; i < plen; i++) begin
            payload.push_back(gmii_rx_pkg::byte_t'($random(seed)));
        end
        case (kind)
            DST_UCAST: payload[0][0] = 1'b0;
            DST_MCAST: begin
                // ipv4 multicast prefix
                payload[0] = 8'h01;
                payload[1] = 8'h00;
                payload[2] = 8'h5E;
            end
            DST_BCAST: begin
                for (int i = 0; i < 6; i++) begin
                    payload[i] = 8'hFF;
                end
            end
            default: ;
        endcase
    endtask

    task automatic send_frame(input string name, input bit bad_fcs, input int err_pos,
                              input int gap);
        byte_q_t frame;
        frame = build_frame(payload, bad_fcs);
        foreach (payload[i]) begin
            exp_data_q.push_back(payload[i]);
            exp_last_q.push_back(i == payload.size() - 1);
        end
        exp_stat_q.push_back(expect_status(payload, bad_fcs, err_pos >= 0,
                                           int'(cfg_max_pkt_len)));
        exp_name_q.push_back(name);
        foreach (frame[i]) begin
            @(posedge clk);
            #1;
            gmii_rxd   = frame[i];
            gmii_rx_dv = 1'b1;
            gmii_rx_er = (i == err_pos);
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
            gmii_rxd   = '0;
            gmii_rx_dv = 1'b0;
            gmii_rx_er = 1'b0;
        end
        frames_sent++;
    endtask

    // output stream and status against the reference queues
    always @(posedge clk) begin
        exp_stat_t st;
        string     nm;
        if (!reset_crc && !rx_last) begin
            check_equal("status pulse outside rx_last", 32'h0,
                        {stat_pkt_good, stat_pkt_bad, stat_err_bad_fcs, stat_err_oversize,
                         stat_err_bad_block, stat_pkt_ucast, stat_pkt_mcast, stat_pkt_bcast});
        end
        if (!reset_crc && rx_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("stray output byte %0h while no frame was expected", rx_data);
                $display(">>> FAIL");
                $fatal(1, "stray output frame");
            end else begin
                nm = exp_name_q[0];
                check_equal({nm, " rx_data"}, exp_data_q.pop_front(), rx_data);
                check_equal({nm, " rx_last"}, exp_last_q.pop_front(), rx_last);
                if (rx_last) begin
                    st = exp_stat_q.pop_front();
                    void'(exp_name_q.pop_front());
                    check_equal({nm, " rx_bad"}, st.bad, rx_bad);
                    check_equal({nm, " stat_pkt_len"}, st.len, stat_pkt_len);
                    check_equal({nm, " stat_pkt_good"}, st.good, stat_pkt_good);
                    check_equal({nm, " stat_pkt_bad"}, st.bad, stat_pkt_bad);
                    check_equal({nm, " stat_err_bad_fcs"}, st.bad_fcs, stat_err_bad_fcs);
                    check_equal({nm, " stat_err_oversize"}, st.oversize, stat_err_oversize);
                    check_equal({nm, " stat_err_bad_block"}, st.bad_block, stat_err_bad_block);
                    check_equal({nm, " stat_pkt_ucast"}, st.ucast, stat_pkt_ucast);
                    check_equal({nm, " stat_pkt_mcast"}, st.mcast, stat_pkt_mcast);
                    check_equal({nm, " stat_pkt_bcast"}, st.bcast, stat_pkt_bcast);
                    frames_seen++;
                end
            end
        end
    end

    initial begin
        int plen;
        int gap;
        bit corrupt;
        clk             = 1'b0;
        reset_crc       = 1'b1;
        gmii_rxd        = '0;
        gmii_rx_dv      = 1'b0;
        gmii_rx_er      = 1'b0;
        cfg_max_pkt_len = 16'd1518;
        repeat (5) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        repeat (3) @(posedge clk);

        make_payload(60, DST_UCAST);
        send_frame("good_frame", 1'b0, -1, 16);
        make_payload(60, DST_UCAST);
        send_frame("bad_fcs", 1'b1, -1, 16);
        // error on payload byte 30 with a broken fcs as well
        make_payload(60, DST_UCAST);
        send_frame("rx_error", 1'b1, 38, 16);

        cfg_max_pkt_len = 16'd100;
        make_payload(116, DST_UCAST);
        send_frame("oversize_120", 1'b0, -1, 16);
        make_payload(96, DST_UCAST);
        send_frame("at_limit_100", 1'b0, -1, 16);
        cfg_max_pkt_len = 16'd1518;

        make_payload(60, DST_BCAST);
        send_frame("broadcast", 1'b0, -1, 16);
        make_payload(60, DST_MCAST);
        send_frame("multicast", 1'b0, -1, 16);
        make_payload(60, DST_UCAST);
        send_frame("unicast", 1'b0, -1, 16);

        for (int n = 0; n < 30; n++) begin
            plen    = 60 + ({$random(seed)} % 137);
            gap     = 12 + ({$random(seed)} % 9);
            corrupt = (({$random(seed)} % 5) == 0);
            make_payload(plen, DST_RANDOM);
            send_frame($sformatf("random_%0d", n), corrupt, -1, gap);
        end

        for (int i = 0; i < 100 && frames_seen != frames_sent; i++) begin
            @(posedge clk);
        end
        if (frames_seen != frames_sent) begin
            $display("frames missing at end of run: sent %0d received %0d",
                     frames_sent, frames_seen);
            $display(">>> FAIL");
            $fatal(1, "missing output frames");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // longest directed frame plus gap, then the random frames at their upper bound
    initial begin
        int wd_cycles;
        wd_cycles = 8 * (8 + 120 + 16) + 30 * (8 + 200 + 20) + 200;
        #(wd_cycles * 20);
        $display("watchdog expired before all frames were received");
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- sim.f
+incdir+dv
logic/gmii_rx_pkg.sv
logic/gmii_pipe_if.sv
logic/gmii_delay_line.sv
logic/eth_fcs_check.sv
logic/eth_addr_classify.sv
logic/eth_rx_fsm.sv
logic/gmii_frame_rx.sv
dv/gmii_frame_rx_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sim.f --top-module gmii_frame_rx_tb -o gmii_frame_rx_sim

./obj_dir/gmii_frame_rx_sim
